// ==== icache.f ====
icache_pkg.sv
icache_data_mem.sv
icache_tag_mem.sv
icache_line_reader.sv
icache_control.sv
icache.sv
icache_checker.sv
icache_tb.sv

// ==== icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache
  import icache_pkg::*;
(
  input logic clk,
  input logic rst_n,

  // processor fetch interface
  input addr_t addr,
  input logic addr_valid,
  output logic addr_ready,
  output group_t result,
  output logic result_valid,

  // AXI read address channel
  output logic [31:0] araddr,
  output logic arvalid,
  input logic arready,

  // AXI read data channel
  input word_t rdata,
  input logic rvalid,
  input logic rlast,
  output logic rready
);

  // lookup path
  logic lookup_re;
  overhead_t rd_entry;

  // refill path into the memories
  fill_t fill;
  logic fill_we;

  // control to line reader
  logic line_req;
  addr_t line_addr;
  line_t line_data;
  logic line_done;

  icache_control u_control (
    .clk(clk),
    .rst_n(rst_n),
    .addr(addr),
    .addr_valid(addr_valid),
    .addr_ready(addr_ready),
    .result_valid(result_valid),
    .lookup_re(lookup_re),
    .rd_entry(rd_entry),
    .fill(fill),
    .fill_we(fill_we),
    .line_req(line_req),
    .line_addr(line_addr),
    .line_data(line_data),
    .line_done(line_done)
  );

  // lookups use the live address
  // the result group comes straight from here
  icache_data_mem u_data_mem (
    .clk(clk),
    .lookup_re(lookup_re),
    .rd_laddr(addr.laddr),
    .rd_waddr(addr.waddr),
    .rd_group(result),
    .fill(fill),
    .fill_we(fill_we)
  );

  icache_tag_mem u_tag_mem (
    .clk(clk),
    .rst_n(rst_n),
    .lookup_re(lookup_re),
    .rd_laddr(addr.laddr),
    .rd_entry(rd_entry),
    .fill(fill),
    .fill_we(fill_we)
  );

  icache_line_reader u_line_reader (
    .clk(clk),
    .rst_n(rst_n),
    .line_req(line_req),
    .line_addr(line_addr),
    .line_data(line_data),
    .line_done(line_done),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rvalid(rvalid),
    .rlast(rlast),
    .rready(rready)
  );

endmodule

`default_nettype wire

// ==== icache_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_checker
  import icache_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input int test_id,
  input addr_t addr,
  input logic addr_valid,
  input logic addr_ready,
  input group_t result,
  input logic result_valid,
  input logic [31:0] araddr,
  input logic arvalid,
  input logic arready,
  input logic rvalid,
  input logic rready,
  input logic rlast,
  output int errors
);

  // own copy of the tag state
  logic model_valid [LNUM];
  tag_t model_tag [LNUM];

  // request in flight
  addr_t req_addr;
  logic in_req;
  logic pred_miss;
  int bursts_req;
  int beats;

  // expectation for the cycle after an acceptance
  logic check_next;
  logic want_result;

  function automatic word_t mem_word(input logic [31:0] byte_addr);
    return byte_addr * 32'd2654435761 + 32'h1234;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0: return "reset_state";
      1: return "cold_miss";
      2: return "hit_groups";
      3: return "conflict_eviction";
      default: return "random_stream";
    endcase
  endfunction

  task automatic value_error(input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("error %s expected %h actual %h", test_name(test_id), exp, act);
  endtask

  task automatic plain_error(input string msg);
    errors++;
    $display("%s: %s", test_name(test_id), msg);
  endtask

  // all ports sampled at the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < LNUM; i++) begin
        model_valid[i] = 1'b0;
        model_tag[i] = '0;
      end
      in_req = 1'b0;
      pred_miss = 1'b0;
      check_next = 1'b0;
      want_result = 1'b0;
      bursts_req = 0;
      beats = 0;
      errors = 0;
    end else begin
      if (check_next) begin
        check_next = 1'b0;
        if (want_result && !result_valid) begin
          plain_error("result_valid missing in the cycle after a hitting acceptance");
        end
        if (!want_result && result_valid) begin
          plain_error("result_valid came on a predicted miss");
        end
      end

      // end of request, compare both words and update the model
      if (result_valid) begin
        if (!in_req) begin
          plain_error("result_valid with no request in flight");
        end else begin
          if (result[0] !== mem_word(req_addr)) begin
            value_error(mem_word(req_addr), result[0]);
          end
          if (result[1] !== mem_word(req_addr + 32'd4)) begin
            value_error(mem_word(req_addr + 32'd4), result[1]);
          end
          model_valid[req_addr.laddr] = 1'b1;
          model_tag[req_addr.laddr] = req_addr.tag;
          in_req = 1'b0;
        end
      end

      // burst address must be line aligned
      if (arvalid && arready) begin
        if (araddr !== {req_addr.tag, req_addr.laddr, 5'b0}) begin
          value_error({req_addr.tag, req_addr.laddr, 5'b0}, araddr);
        end
        bursts_req++;
        beats = 0;
      end
      if (rvalid && rready) begin
        beats++;
        if (rlast && beats != BURST_LEN) begin
          value_error(BURST_LEN, beats);
        end
      end
      // memory only offers beats during the data phase of a burst
      if (rvalid && !rready) begin
        plain_error("memory offered a beat while rready was low");
      end
      if (arvalid && !(in_req && pred_miss)) begin
        plain_error("arvalid raised without a predicted miss");
      end

      if (addr_valid && addr_ready) begin
        if (!in_req) begin
          // first acceptance decides hit or miss
          in_req = 1'b1;
          req_addr = addr;
          pred_miss = !(model_valid[addr.laddr] && model_tag[addr.laddr] == addr.tag);
          want_result = !pred_miss;
          bursts_req = 0;
        end else begin
          // re-acceptance after the refill
          if (addr !== req_addr) begin
            value_error(req_addr, addr);
          end
          if (bursts_req != 1) begin
            value_error(1, bursts_req);
          end
          want_result = 1'b1;
        end
        check_next = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== icache_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_control
  import icache_pkg::*;
(
  input logic clk,
  input logic rst_n,

  // processor request side
  input addr_t addr,
  input logic addr_valid,
  output logic addr_ready,
  output logic result_valid,

  // lookup into both memories
  output logic lookup_re,
  input overhead_t rd_entry,

  // refill into both memories
  output fill_t fill,
  output logic fill_we,

  // line reader
  output logic line_req,
  output addr_t line_addr,
  input line_t line_data,
  input logic line_done
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  // address of the request in flight
  addr_t req_q;

  logic accept;
  logic hit;

  // only IDLE takes a new address
  assign addr_ready = (state == IDLE);
  assign accept = addr_valid && addr_ready;

  // both memories read on the accepting edge
  assign lookup_re = accept;

  // entry read back is for req_q in COMPARE
  assign hit = rd_entry.valid && (rd_entry.tag == req_q.tag);

  // group on result is valid in this same cycle
  assign result_valid = (state == COMPARE) && hit;

  // request is up from the miss decision
  // it drops as soon as the line comes back
  assign line_req = ((state == COMPARE) && !hit) ||
                    (state == REFILL_REQ) ||
                    ((state == REFILL_WAIT) && !line_done);
  assign line_addr = req_q;

  // one write pulse per refill
  assign fill_we = (state == REFILL_WRITE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = COMPARE;
        end
      end
      COMPARE: begin
        // hit finishes here, a miss starts the refill
        if (hit) begin
          state_next = IDLE;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        // reader is in its address phase now
        state_next = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (line_done) begin
          state_next = REFILL_WRITE;
        end
      end
      REFILL_WRITE: begin
        // requester is still holding the address
        // so the next acceptance hits the fresh line
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // capture the address on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= addr;
    end
  end

  // stage the returned line with its index and tag
  always_ff @(posedge clk) begin
    if (state == REFILL_WAIT && line_done) begin
      fill.laddr <= req_q.laddr;
      fill.tag <= req_q.tag;
      fill.line <= line_data;
    end
  end

endmodule

`default_nettype wire

// ==== icache_data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data_mem
  import icache_pkg::*;
(
  input logic clk,

  // lookup port
  input logic lookup_re,
  input laddr_t rd_laddr,
  input waddr_t rd_waddr,
  output group_t rd_group,

  // refill port
  input fill_t fill,
  input logic fill_we
);

  // one full line per entry
  line_t lines [LNUM];

  // first word of the fetch group
  waddr_t grp_base;

  // fetch addresses are group aligned
  // mask the low word bits anyway so the slice never runs past the line
  assign grp_base = rd_waddr & ~waddr_t'(RBKSZ - 1);

  // refill writes the whole line in one edge
  always_ff @(posedge clk) begin
    if (fill_we) begin
      lines[fill.laddr] <= fill.line;
    end
  end

  // group read lands one cycle after the strobe
  // rd_group holds its value between lookups
  always_ff @(posedge clk) begin
    if (lookup_re) begin
      rd_group <= lines[rd_laddr][grp_base +: RBKSZ];
    end
  end

endmodule

`default_nettype wire

// ==== icache_line_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_line_reader
  import icache_pkg::*;
(
  input logic clk,
  input logic rst_n,

  // request from control
  input logic line_req,
  input addr_t line_addr,
  output line_t line_data,
  output logic line_done,

  // AXI read address channel
  output logic [31:0] araddr,
  output logic arvalid,
  input logic arready,

  // AXI read data channel
  input word_t rdata,
  input logic rvalid,
  input logic rlast,
  output logic rready
);

  rd_state_t state;

  // slot of the next beat in the line
  logic [$clog2(BURST_LEN)-1:0] beat_cnt;

  // line aligned base of the requested address
  addr_t line_base;

  // keep tag and index, drop word and byte offset
  assign line_base = '{tag: line_addr.tag, laddr: line_addr.laddr, waddr: '0, boff: '0};

  // handshake levels straight from the state
  assign arvalid = (state == RD_ADDR);
  assign rready = (state == RD_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RD_IDLE;
      beat_cnt <= '0;
      line_done <= 1'b0;
    end else begin
      // done is a single cycle pulse
      line_done <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (line_req) begin
            state <= RD_ADDR;
            beat_cnt <= '0;
          end
        end
        RD_ADDR: begin
          // hold the address phase until the slave takes it
          if (arready) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            // last beat closes the burst wherever it falls
            if (rlast) begin
              state <= RD_IDLE;
              line_done <= 1'b1;
            end
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // address latched as the burst starts
  always_ff @(posedge clk) begin
    if (state == RD_IDLE && line_req) begin
      araddr <= line_base;
    end
  end

  // each accepted beat goes to its own word slot
  // gaps in rvalid simply leave the counter where it is
  always_ff @(posedge clk) begin
    if (state == RD_DATA && rvalid) begin
      line_data[beat_cnt] <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // cache geometry
  localparam int WDSZ = 32;
  localparam int WBKSZ = 8;
  localparam int RBKSZ = 2;
  localparam int LNUM = 16;
  localparam int TAGSZ = 23;

  // one refill burst fetches a whole line
  localparam int BURST_LEN = WBKSZ;

  typedef logic [WDSZ-1:0] word_t;
  typedef logic [$clog2(LNUM)-1:0] laddr_t;
  typedef logic [$clog2(WBKSZ)-1:0] waddr_t;
  typedef logic [TAGSZ-1:0] tag_t;

  // byte address split into cache fields
  typedef struct packed {
    tag_t tag;
    laddr_t laddr;
    waddr_t waddr;
    logic [1:0] boff;
  } addr_t;

  // one tag memory entry
  typedef struct packed {
    logic valid;
    tag_t tag;
  } overhead_t;

  typedef word_t [WBKSZ-1:0] line_t;
  typedef word_t [RBKSZ-1:0] group_t;

  // refill written into data and tag memories at once
  typedef struct packed {
    laddr_t laddr;
    tag_t tag;
    line_t line;
  } fill_t;

  typedef enum logic [2:0] {IDLE, COMPARE, REFILL_REQ, REFILL_WAIT, REFILL_WRITE} ctrl_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

// ==== icache_tag_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tag_mem
  import icache_pkg::*;
(
  input logic clk,
  input logic rst_n,

  // lookup port
  input logic lookup_re,
  input laddr_t rd_laddr,
  output overhead_t rd_entry,

  // refill port
  input fill_t fill,
  input logic fill_we
);

  // valid bit and tag per line
  overhead_t entries [LNUM];

  // entries live in flops so reset can invalidate the whole cache
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LNUM; i++) begin
        entries[i] <= '0;
      end
      rd_entry <= '0;
    end else begin
      // refill marks the line resident
      if (fill_we) begin
        entries[fill.laddr] <= '{valid: 1'b1, tag: fill.tag};
      end
      // registered read in step with the data memory
      if (lookup_re) begin
        rd_entry <= entries[rd_laddr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  // fetches issued over all tests
  localparam int NUM_REQ = 308;
  // worst case refill with stalls stays well under 40 cycles
  localparam int CYCLE_LIMIT = NUM_REQ * 40 + 1000;

  logic clk;
  logic rst_n;
  addr_t addr;
  logic addr_valid;
  logic addr_ready;
  group_t result;
  logic result_valid;
  logic [31:0] araddr;
  logic arvalid;
  logic arready;
  word_t rdata;
  logic rvalid;
  logic rlast;
  logic rready;

  int test_id;
  int tb_errors;
  int chk_errors;
  int cycles;

  icache icache_i (.*);

  icache_checker checker_i (.*, .errors(chk_errors));

  // memory contents as a function of the byte address
  function automatic word_t mem_word(input logic [31:0] byte_addr);
    return byte_addr * 32'd2654435761 + 32'h1234;
  endfunction

  // aligned fetch address from tag, line index and group number
  function automatic addr_t group_addr(input int t, input int i, input int g);
    addr_t a;
    a.tag = tag_t'(t);
    a.laddr = laddr_t'(i);
    a.waddr = waddr_t'(g * RBKSZ);
    a.boff = 2'b00;
    return a;
  endfunction

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_reset_level(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      tb_errors++;
      $display("error reset_state expected %b actual %b on %s", exp, act, sig);
    end
  endtask

  // present one address and hold it until the result pulse
  task automatic fetch(input addr_t a);
    addr <= a;
    addr_valid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!result_valid);
  endtask

  // one burst: address accept after 0..3 cycles, 8 beats with random gaps
  task automatic serve_burst(input logic [31:0] base);
    repeat ($urandom % 4) @(posedge clk);
    arready <= 1'b1;
    @(posedge clk);
    arready <= 1'b0;
    for (int k = 0; k < BURST_LEN; k++) begin
      if ($urandom % 3 == 0) begin
        rvalid <= 1'b0;
        @(posedge clk);
      end
      rvalid <= 1'b1;
      rdata <= mem_word(base + 32'(4 * k));
      rlast <= (k == BURST_LEN - 1);
      @(posedge clk);
    end
    rvalid <= 1'b0;
    rlast <= 1'b0;
  endtask

  // memory model on the read channel
  initial begin
    forever begin
      @(posedge clk);
      if (arvalid) begin
        serve_burst(araddr);
      end
    end
  end

  initial begin
    int t;
    int i;
    int g;
    void'($urandom(40917));
    rst_n = 1'b0;
    addr = '0;
    addr_valid = 1'b0;
    arready = 1'b0;
    rdata = '0;
    rvalid = 1'b0;
    rlast = 1'b0;
    test_id = 0;
    tb_errors = 0;
    cycles = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_level("addr_ready", 1'b1, addr_ready);
    check_reset_level("result_valid", 1'b0, result_valid);
    check_reset_level("arvalid", 1'b0, arvalid);
    check_reset_level("rready", 1'b0, rready);

    // cold miss into line 2
    test_id <= 1;
    fetch(group_addr(5, 2, 1));

    // every group of the resident line hits
    test_id <= 2;
    for (g = 0; g < WBKSZ / RBKSZ; g++) begin
      fetch(group_addr(5, 2, g));
    end

    // same index, other tag evicts, then the old tag misses again
    test_id <= 3;
    fetch(group_addr(9, 2, 0));
    fetch(group_addr(9, 2, 2));
    fetch(group_addr(5, 2, 3));

    // small pool of 3 tags over 4 lines
    test_id <= 4;
    repeat (300) begin
      t = $urandom % 3;
      i = $urandom % 4;
      g = $urandom % 4;
      fetch(group_addr(t, i, g));
    end
    addr_valid <= 1'b0;
    repeat (5) @(posedge clk);

    $display("checker errors %0d, testbench errors %0d", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a request never completed", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f icache.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
